// ==== hw/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111
    } opcode_t;

    // alu operation is {alt bit, funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111
    } alu_op_t;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // loads and stores share the size codes
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    localparam word_t INSTR_BYTES = 32'd4;
    localparam word_t RESET_PC    = 32'h0000_0000;
    localparam int    NUM_REGS    = 32;

endpackage

// ==== hw/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [3:0]  byte_en_t;

    // one data bus request as seen on the pins
    typedef struct packed {
        addr_t              addr;
        cpu_isa_pkg::word_t wdata;
        byte_en_t           byte_en;
        logic               as_l;
        logic               we_l;
    } bus_req_t;

    localparam byte_en_t BE_NONE = 4'b0000;
    localparam byte_en_t BE_BYTE = 4'b0001;
    localparam byte_en_t BE_HALF = 4'b0011;
    localparam byte_en_t BE_ALL  = 4'b1111;

    // low address bits that pick the byte lane
    localparam int BYTE_OFFSET_BITS = 2;

endpackage

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  cpu_isa_pkg::reg_idx_t rs1_idx,
    input  cpu_isa_pkg::reg_idx_t rs2_idx,
    input  cpu_isa_pkg::reg_idx_t rd_idx,
    input  logic                  write_en,
    input  cpu_isa_pkg::word_t    write_data,
    output cpu_isa_pkg::word_t    rs1_data,
    output cpu_isa_pkg::word_t    rs2_data
);

    cpu_isa_pkg::word_t regs [cpu_isa_pkg::NUM_REGS];

    // x0 is never written, so it reads as zero
    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd_idx != '0)) begin
            regs[rd_idx] <= write_data;
        end
    end

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_isa_pkg::alu_op_t op,
    input  cpu_isa_pkg::word_t   a,
    input  cpu_isa_pkg::word_t   b,
    output cpu_isa_pkg::word_t   result,
    output logic                 zero
);

    logic [4:0] shamt;

    // only the low five bits count for shifts
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_isa_pkg::ALU_ADD:
                result = a + b;
            cpu_isa_pkg::ALU_SUB:
                result = a - b;
            cpu_isa_pkg::ALU_SLL:
                result = a << shamt;
            cpu_isa_pkg::ALU_SLT:
                result = {31'b0, $signed(a) < $signed(b)};
            cpu_isa_pkg::ALU_SLTU:
                result = {31'b0, a < b};
            cpu_isa_pkg::ALU_XOR:
                result = a ^ b;
            cpu_isa_pkg::ALU_SRL:
                result = a >> shamt;
            cpu_isa_pkg::ALU_SRA:
                result = $signed(a) >>> shamt;
            cpu_isa_pkg::ALU_OR:
                result = a | b;
            cpu_isa_pkg::ALU_AND:
                result = a & b;
            // undefined alt/funct3 pairs fall back to add
            default:
                result = a + b;
        endcase
    end

    // used with sub for beq and bne
    assign zero = (result == '0);

endmodule

// ==== hw/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  cpu_bus_pkg::addr_t    addr,
    input  logic [2:0]            funct3,
    input  cpu_isa_pkg::word_t    store_data,
    input  cpu_isa_pkg::word_t    bus_data,
    output cpu_bus_pkg::byte_en_t byte_en,
    output cpu_isa_pkg::word_t    wdata,
    output cpu_isa_pkg::word_t    load_data
);

    logic [cpu_bus_pkg::BYTE_OFFSET_BITS-1:0] offset;
    logic [4:0]                               lane_shift;
    logic                                     aligned;
    cpu_isa_pkg::word_t                       lane;

    assign offset     = addr[cpu_bus_pkg::BYTE_OFFSET_BITS-1:0];
    assign lane_shift = {offset, 3'b000};

    // lane enables by access size, none when misaligned
    always_comb begin
        case (funct3)
            cpu_isa_pkg::F3_SB, cpu_isa_pkg::F3_LBU:
                byte_en = cpu_bus_pkg::BE_BYTE << offset;
            cpu_isa_pkg::F3_SH, cpu_isa_pkg::F3_LHU:
                byte_en = offset[0] ? cpu_bus_pkg::BE_NONE : (cpu_bus_pkg::BE_HALF << offset);
            cpu_isa_pkg::F3_SW:
                byte_en = (offset == '0) ? cpu_bus_pkg::BE_ALL : cpu_bus_pkg::BE_NONE;
            default:
                byte_en = cpu_bus_pkg::BE_NONE;
        endcase
    end

    assign aligned = (byte_en != cpu_bus_pkg::BE_NONE);

    // store data moves up to its lane
    assign wdata = aligned ? (store_data << lane_shift) : '0;

    // addressed lane brought down to bit 0
    assign lane = bus_data >> lane_shift;

    always_comb begin
        if (!aligned) begin
            load_data = '0;
        end else begin
            case (funct3)
                cpu_isa_pkg::F3_LB:
                    load_data = {{24{lane[7]}}, lane[7:0]};
                cpu_isa_pkg::F3_LBU:
                    load_data = {24'b0, lane[7:0]};
                cpu_isa_pkg::F3_LH:
                    load_data = {{16{lane[15]}}, lane[15:0]};
                cpu_isa_pkg::F3_LHU:
                    load_data = {16'b0, lane[15:0]};
                cpu_isa_pkg::F3_LW:
                    load_data = lane;
                default:
                    load_data = '0;
            endcase
        end
    end

endmodule

// ==== hw/control_fsm.sv ====
`timescale 1ns/1ps

module control_fsm (
    input  logic                  Clock,
    input  logic                  Reset_L,
    input  cpu_isa_pkg::word_t    instruction,
    input  logic                  dtack,
    input  cpu_isa_pkg::word_t    alu_result,
    input  logic                  alu_zero,
    input  cpu_isa_pkg::word_t    load_data,
    output cpu_isa_pkg::reg_idx_t rs1_idx,
    output cpu_isa_pkg::reg_idx_t rs2_idx,
    output cpu_isa_pkg::reg_idx_t rd_idx,
    output logic                  reg_write_en,
    output cpu_isa_pkg::word_t    reg_write_data,
    output cpu_isa_pkg::alu_op_t  alu_op,
    output logic                  alu_use_imm,
    output cpu_isa_pkg::word_t    imm,
    output logic [2:0]            funct3,
    output cpu_bus_pkg::addr_t    addr,
    output logic                  as_l,
    output logic                  we_l
);

    typedef enum logic [2:0] {
        S_FETCH_WAIT,
        S_LATCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM_WAIT,
        S_MEM_DONE,
        S_COMPLETE
    } state_t;

    state_t                state;
    cpu_isa_pkg::word_t    pc;
    cpu_isa_pkg::word_t    ir;
    cpu_isa_pkg::opcode_t  opcode;
    logic                  take_branch;
    logic                  shift_alt;
    cpu_isa_pkg::word_t    imm_i;
    cpu_isa_pkg::word_t    imm_s;
    cpu_isa_pkg::word_t    imm_b;
    cpu_isa_pkg::word_t    imm_u;

    // instruction fields
    assign opcode  = cpu_isa_pkg::opcode_t'(ir[6:0]);
    assign rd_idx  = ir[11:7];
    assign funct3  = ir[14:12];
    assign rs1_idx = ir[19:15];
    assign rs2_idx = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};

    // bit 30 of an immediate op is only an alt bit for srli/srai
    assign shift_alt = (funct3 == 3'b101) & ir[30];

    // pc goes out while no data access is running
    assign addr = as_l ? pc : alu_result;

    always_comb begin
        case (opcode)
            cpu_isa_pkg::OP_LOAD:
                reg_write_data = load_data;
            cpu_isa_pkg::OP_LUI:
                reg_write_data = imm;
            default:
                reg_write_data = alu_result;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (state == S_LATCH) begin
            ir <= instruction;
        end
        if (state == S_DECODE) begin
            case (opcode)
                cpu_isa_pkg::OP_STORE:  imm <= imm_s;
                cpu_isa_pkg::OP_BRANCH: imm <= imm_b;
                cpu_isa_pkg::OP_LUI:    imm <= imm_u;
                default:                imm <= imm_i;
            endcase
        end
    end

    always_ff @(posedge Clock or negedge Reset_L) begin
        if (!Reset_L) begin
            state        <= S_FETCH_WAIT;
            pc           <= cpu_isa_pkg::RESET_PC;
            as_l         <= 1'b1;
            we_l         <= 1'b1;
            reg_write_en <= 1'b0;
            alu_op       <= cpu_isa_pkg::ALU_ADD;
            alu_use_imm  <= 1'b0;
            take_branch  <= 1'b0;
        end else begin
            case (state)
                // instruction memory needs a cycle to show the word
                S_FETCH_WAIT: state <= S_LATCH;
                S_LATCH:      state <= S_DECODE;
                S_DECODE: begin
                    state       <= S_EXECUTE;
                    take_branch <= 1'b0;
                    case (opcode)
                        cpu_isa_pkg::OP_R: begin
                            alu_op       <= cpu_isa_pkg::alu_op_t'({ir[30], funct3});
                            alu_use_imm  <= 1'b0;
                            reg_write_en <= 1'b1;
                        end
                        cpu_isa_pkg::OP_I: begin
                            alu_op       <= cpu_isa_pkg::alu_op_t'({shift_alt, funct3});
                            alu_use_imm  <= 1'b1;
                            reg_write_en <= 1'b1;
                        end
                        cpu_isa_pkg::OP_LOAD, cpu_isa_pkg::OP_STORE: begin
                            alu_op      <= cpu_isa_pkg::ALU_ADD;
                            alu_use_imm <= 1'b1;
                        end
                        cpu_isa_pkg::OP_BRANCH: begin
                            alu_op      <= cpu_isa_pkg::ALU_SUB;
                            alu_use_imm <= 1'b0;
                        end
                        cpu_isa_pkg::OP_LUI: reg_write_en <= 1'b1;
                        // unknown opcodes just step the pc
                        default: ;
                    endcase
                end
                S_EXECUTE: begin
                    // register write for alu ops and lui lands on this edge
                    reg_write_en <= 1'b0;
                    if (opcode == cpu_isa_pkg::OP_LOAD || opcode == cpu_isa_pkg::OP_STORE) begin
                        state <= S_MEM_WAIT;
                        as_l  <= 1'b0;
                        we_l  <= (opcode != cpu_isa_pkg::OP_STORE);
                    end else begin
                        state <= S_COMPLETE;
                    end
                    if (opcode == cpu_isa_pkg::OP_BRANCH) begin
                        take_branch <= ((funct3 == cpu_isa_pkg::F3_BEQ) && alu_zero) ||
                                       ((funct3 == cpu_isa_pkg::F3_BNE) && !alu_zero);
                    end
                end
                // request held until the memory acknowledges
                S_MEM_WAIT: begin
                    if (dtack) begin
                        state <= S_MEM_DONE;
                    end
                end
                S_MEM_DONE: begin
                    state        <= S_COMPLETE;
                    reg_write_en <= (opcode == cpu_isa_pkg::OP_LOAD);
                end
                S_COMPLETE: begin
                    state        <= S_FETCH_WAIT;
                    reg_write_en <= 1'b0;
                    as_l         <= 1'b1;
                    we_l         <= 1'b1;
                    pc           <= take_branch ? (pc + imm) : (pc + cpu_isa_pkg::INSTR_BYTES);
                end
                default: state <= S_FETCH_WAIT;
            endcase
        end
    end

endmodule

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                   Clock,
    input  logic                   Reset_L,
    input  cpu_isa_pkg::word_t     instruction,
    input  cpu_isa_pkg::word_t     data_in,
    input  logic                   dtack,
    output cpu_bus_pkg::bus_req_t  bus
);

    cpu_isa_pkg::reg_idx_t rs1_idx;
    cpu_isa_pkg::reg_idx_t rs2_idx;
    cpu_isa_pkg::reg_idx_t rd_idx;
    logic                  reg_write_en;
    cpu_isa_pkg::word_t    reg_write_data;
    cpu_isa_pkg::word_t    rs1_data;
    cpu_isa_pkg::word_t    rs2_data;
    cpu_isa_pkg::alu_op_t  alu_op;
    logic                  alu_use_imm;
    cpu_isa_pkg::word_t    imm;
    cpu_isa_pkg::word_t    alu_result;
    logic                  alu_zero;
    logic [2:0]            funct3;
    cpu_isa_pkg::word_t    load_data;
    cpu_isa_pkg::word_t    lsu_wdata;
    cpu_bus_pkg::byte_en_t lsu_byte_en;
    cpu_bus_pkg::addr_t    addr;
    logic                  as_l;
    logic                  we_l;

    control_fsm i_control_fsm (
        .Clock          (Clock),
        .Reset_L        (Reset_L),
        .instruction    (instruction),
        .dtack          (dtack),
        .alu_result     (alu_result),
        .alu_zero       (alu_zero),
        .load_data      (load_data),
        .rs1_idx        (rs1_idx),
        .rs2_idx        (rs2_idx),
        .rd_idx         (rd_idx),
        .reg_write_en   (reg_write_en),
        .reg_write_data (reg_write_data),
        .alu_op         (alu_op),
        .alu_use_imm    (alu_use_imm),
        .imm            (imm),
        .funct3         (funct3),
        .addr           (addr),
        .as_l           (as_l),
        .we_l           (we_l)
    );

    reg_file i_reg_file (
        .Clock      (Clock),
        .Reset_L    (Reset_L),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rd_idx     (rd_idx),
        .write_en   (reg_write_en),
        .write_data (reg_write_data),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data)
    );

    // second operand is rs2 or the immediate
    alu i_alu (
        .op     (alu_op),
        .a      (rs1_data),
        .b      (alu_use_imm ? imm : rs2_data),
        .result (alu_result),
        .zero   (alu_zero)
    );

    load_store_unit i_load_store_unit (
        .addr       (alu_result),
        .funct3     (funct3),
        .store_data (rs2_data),
        .bus_data   (data_in),
        .byte_en    (lsu_byte_en),
        .wdata      (lsu_wdata),
        .load_data  (load_data)
    );

    assign bus = '{addr: addr, wdata: lsu_wdata, byte_en: lsu_byte_en, as_l: as_l, we_l: we_l};

endmodule

// ==== tb/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

    localparam int RESET_CYCLES     = 8;
    localparam int CYCLES_PER_ENTRY = 12;

    localparam cpu_isa_pkg::reg_idx_t R0 = 5'd0;
    localparam cpu_isa_pkg::reg_idx_t R1 = 5'd1;
    localparam cpu_isa_pkg::reg_idx_t R2 = 5'd2;
    localparam cpu_isa_pkg::reg_idx_t R3 = 5'd3;
    localparam cpu_isa_pkg::reg_idx_t R4 = 5'd4;
    localparam cpu_isa_pkg::reg_idx_t R5 = 5'd5;

    // a negative and a small positive operand
    localparam cpu_isa_pkg::word_t OP_A      = 32'h8765_4321;
    localparam cpu_isa_pkg::word_t OP_B      = 32'h0000_0013;
    localparam logic [11:0]        IMM_N     = 12'hF93;
    localparam cpu_isa_pkg::word_t IMM_X     = {{20{IMM_N[11]}}, IMM_N};
    localparam cpu_isa_pkg::word_t ST_VAL    = 32'hA1B2_C3D4;
    localparam cpu_isa_pkg::word_t LOAD_DATA = 32'h7E81_C340;
    localparam cpu_bus_pkg::addr_t RES_ADDR  = 32'h0000_0100;
    localparam cpu_bus_pkg::addr_t ST_BASE   = 32'h0000_0200;
    localparam cpu_bus_pkg::addr_t LD_BASE   = 32'h0000_0300;

    // one program word and what it must do on the bus
    typedef struct packed {
        cpu_isa_pkg::word_t    instr;
        logic                  has_store;
        cpu_bus_pkg::bus_req_t store;
        cpu_bus_pkg::addr_t    next_pc;
    } entry_t;

    logic                  Clock;
    logic                  Reset_L;
    cpu_isa_pkg::word_t    instruction;
    cpu_isa_pkg::word_t    data_in;
    logic                  dtack;
    cpu_bus_pkg::bus_req_t bus;

    entry_t             program_q[$];
    int                 errors;
    int                 cycles;
    int                 cycle_limit;
    int                 wait_left;
    logic               mem_busy;
    logic               acked;
    integer             seed = 32'hf43a;
    cpu_bus_pkg::addr_t pc;

    cpu_top i_dut (
        .Clock       (Clock),
        .Reset_L     (Reset_L),
        .instruction (instruction),
        .data_in     (data_in),
        .dtack       (dtack),
        .bus         (bus)
    );

    always #20 Clock = ~Clock;

    function automatic cpu_isa_pkg::word_t enc_r(logic [6:0] f7, cpu_isa_pkg::reg_idx_t rs2,
            cpu_isa_pkg::reg_idx_t rs1, logic [2:0] f3, cpu_isa_pkg::reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, cpu_isa_pkg::OP_R};
    endfunction

    function automatic cpu_isa_pkg::word_t enc_i(logic [11:0] imm, cpu_isa_pkg::reg_idx_t rs1,
            logic [2:0] f3, cpu_isa_pkg::reg_idx_t rd, cpu_isa_pkg::opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic cpu_isa_pkg::word_t enc_s(logic [11:0] imm, cpu_isa_pkg::reg_idx_t rs2,
            cpu_isa_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], cpu_isa_pkg::OP_STORE};
    endfunction

    function automatic cpu_isa_pkg::word_t enc_b(logic [12:0] off, cpu_isa_pkg::reg_idx_t rs2,
            cpu_isa_pkg::reg_idx_t rs1, logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_isa_pkg::OP_BRANCH};
    endfunction

    task automatic add_entry(cpu_isa_pkg::word_t instr, logic has_store,
            cpu_bus_pkg::bus_req_t store, cpu_bus_pkg::addr_t next_pc);
        entry_t e;
        e.instr     = instr;
        e.has_store = has_store;
        e.store     = store;
        e.next_pc   = next_pc;
        program_q.push_back(e);
    endtask

    task automatic add_plain(cpu_isa_pkg::word_t instr);
        cpu_bus_pkg::addr_t here;
        here = cpu_bus_pkg::addr_t'(program_q.size() * 4);
        add_entry(instr, 1'b0, '0, here + 32'd4);
    endtask

    task automatic add_store(cpu_isa_pkg::word_t instr, cpu_bus_pkg::addr_t addr,
            cpu_isa_pkg::word_t wdata, cpu_bus_pkg::byte_en_t be);
        cpu_bus_pkg::addr_t    here;
        cpu_bus_pkg::bus_req_t req;
        here        = cpu_bus_pkg::addr_t'(program_q.size() * 4);
        req.addr    = addr;
        req.wdata   = wdata;
        req.byte_en = be;
        req.as_l    = 1'b0;
        req.we_l    = 1'b0;
        add_entry(instr, 1'b1, req, here + 32'd4);
    endtask

    task automatic load_const(cpu_isa_pkg::reg_idx_t rd, cpu_isa_pkg::word_t value);
        cpu_isa_pkg::word_t upper;
        // round up so the sign-extended addi lands on value
        upper = value + 32'h800;
        add_plain({upper[31:12], rd, cpu_isa_pkg::OP_LUI});
        add_plain(enc_i(value[11:0], rd, 3'b000, rd, cpu_isa_pkg::OP_I));
    endtask

    task automatic store_result(cpu_isa_pkg::reg_idx_t rs, cpu_isa_pkg::word_t value);
        add_store(enc_s(RES_ADDR[11:0], rs, R0, cpu_isa_pkg::F3_SW), RES_ADDR, value,
                  cpu_bus_pkg::BE_ALL);
    endtask

    task automatic alu_r(logic [6:0] f7, logic [2:0] f3, cpu_isa_pkg::word_t expected);
        add_plain(enc_r(f7, R2, R1, f3, R3));
        store_result(R3, expected);
    endtask

    task automatic alu_i(logic [11:0] imm, logic [2:0] f3, cpu_isa_pkg::word_t expected);
        add_plain(enc_i(imm, R1, f3, R3, cpu_isa_pkg::OP_I));
        store_result(R3, expected);
    endtask

    task automatic store_lane(logic [2:0] f3, int off, cpu_bus_pkg::byte_en_t be,
            cpu_isa_pkg::word_t wdata);
        add_store(enc_s(12'(ST_BASE + off), R4, R0, f3), ST_BASE + off, wdata, be);
    endtask

    task automatic load_check(logic [2:0] f3, int off, cpu_isa_pkg::word_t expected);
        add_plain(enc_i(12'(LD_BASE + off), R0, f3, R5, cpu_isa_pkg::OP_LOAD));
        store_result(R5, expected);
    endtask

    task automatic branch_entry(logic [2:0] f3, cpu_isa_pkg::reg_idx_t rs1,
            cpu_isa_pkg::reg_idx_t rs2, int offset, logic taken);
        cpu_bus_pkg::addr_t here;
        here = cpu_bus_pkg::addr_t'(program_q.size() * 4);
        add_entry(enc_b(13'(offset), rs2, rs1, f3), 1'b0, '0,
                  taken ? (here + offset) : (here + 32'd4));
    endtask

    task automatic build_program();
        logic [7:0]  b;
        logic [15:0] h;
        load_const(R1, OP_A);
        load_const(R2, OP_B);
        alu_r(7'h00, 3'b000, OP_A + OP_B);
        alu_r(7'h20, 3'b000, OP_A - OP_B);
        alu_r(7'h00, 3'b001, OP_A << OP_B[4:0]);
        alu_r(7'h00, 3'b010, ($signed(OP_A) < $signed(OP_B)) ? 32'd1 : 32'd0);
        alu_r(7'h00, 3'b011, (OP_A < OP_B) ? 32'd1 : 32'd0);
        alu_r(7'h00, 3'b100, OP_A ^ OP_B);
        alu_r(7'h00, 3'b101, OP_A >> OP_B[4:0]);
        alu_r(7'h20, 3'b101, cpu_isa_pkg::word_t'($signed(OP_A) >>> OP_B[4:0]));
        alu_r(7'h00, 3'b110, OP_A | OP_B);
        alu_r(7'h00, 3'b111, OP_A & OP_B);
        alu_i(IMM_N, 3'b000, OP_A + IMM_X);
        alu_i(IMM_N, 3'b010, ($signed(OP_A) < $signed(IMM_X)) ? 32'd1 : 32'd0);
        alu_i(IMM_N, 3'b011, (OP_A < IMM_X) ? 32'd1 : 32'd0);
        alu_i(IMM_N, 3'b100, OP_A ^ IMM_X);
        alu_i(IMM_N, 3'b110, OP_A | IMM_X);
        alu_i(IMM_N, 3'b111, OP_A & IMM_X);
        alu_i({7'b0000000, 5'd7}, 3'b001, OP_A << 7);
        alu_i({7'b0000000, 5'd7}, 3'b101, OP_A >> 7);
        alu_i({7'b0100000, 5'd7}, 3'b101, cpu_isa_pkg::word_t'($signed(OP_A) >>> 7));
        // write to x0 is dropped
        add_plain(enc_i(12'h055, R1, 3'b000, R0, cpu_isa_pkg::OP_I));
        store_result(R0, 32'h0);
        // all-zero word is an unknown opcode
        add_plain(32'h0000_0000);

        load_const(R4, ST_VAL);
        for (int off = 0; off < 4; off++) begin
            store_lane(cpu_isa_pkg::F3_SB, off, 4'b0001 << off, ST_VAL << (8 * off));
        end
        store_lane(cpu_isa_pkg::F3_SH, 0, 4'b0011, ST_VAL);
        store_lane(cpu_isa_pkg::F3_SH, 2, 4'b1100, ST_VAL << 16);
        store_lane(cpu_isa_pkg::F3_SH, 1, cpu_bus_pkg::BE_NONE, 32'h0);
        store_lane(cpu_isa_pkg::F3_SH, 3, cpu_bus_pkg::BE_NONE, 32'h0);
        for (int off = 1; off < 4; off++) begin
            store_lane(cpu_isa_pkg::F3_SW, off, cpu_bus_pkg::BE_NONE, 32'h0);
        end

        for (int off = 0; off < 4; off++) begin
            b = LOAD_DATA[8*off +: 8];
            load_check(cpu_isa_pkg::F3_LB, off, {{24{b[7]}}, b});
            load_check(cpu_isa_pkg::F3_LBU, off, {24'b0, b});
        end
        for (int off = 0; off < 4; off += 2) begin
            h = LOAD_DATA[8*off +: 16];
            load_check(cpu_isa_pkg::F3_LH, off, {{16{h[15]}}, h});
            load_check(cpu_isa_pkg::F3_LHU, off, {16'b0, h});
        end
        load_check(cpu_isa_pkg::F3_LW, 0, LOAD_DATA);
        load_check(cpu_isa_pkg::F3_LH, 1, 32'h0);
        load_check(cpu_isa_pkg::F3_LHU, 3, 32'h0);
        load_check(cpu_isa_pkg::F3_LW, 2, 32'h0);

        // forward, then back to the second word, then over the filler
        branch_entry(cpu_isa_pkg::F3_BEQ, R1, R1, 8, 1'b1);
        branch_entry(cpu_isa_pkg::F3_BNE, R1, R2, 12, 1'b1);
        branch_entry(cpu_isa_pkg::F3_BNE, R1, R2, -4, 1'b1);
        add_plain(32'h0000_0000);
        branch_entry(cpu_isa_pkg::F3_BEQ, R1, R2, 8, 1'b0);
        branch_entry(cpu_isa_pkg::F3_BNE, R1, R1, -16, 1'b0);
    endtask

    task automatic check_store(string name, cpu_bus_pkg::bus_req_t expected,
            cpu_bus_pkg::bus_req_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_fetch(string name, cpu_bus_pkg::addr_t expected,
            cpu_bus_pkg::addr_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_strobe(string name, logic expected, logic actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic finish_run();
        $display("run ended after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    // instruction port follows the pc and dtack comes after a random wait
    task automatic drive_memory();
        if (bus.as_l) begin
            mem_busy = 1'b0;
            acked    = 1'b0;
            dtack    = 1'b0;
            if ((bus.addr >> 2) < program_q.size()) begin
                instruction = program_q[bus.addr >> 2].instr;
            end else begin
                instruction = 32'h0;
            end
        end else begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                wait_left = {$random(seed)} % 4;
            end
            if (acked) begin
                dtack = 1'b0;
            end else if (wait_left == 0) begin
                dtack = 1'b1;
                acked = 1'b1;
            end else begin
                dtack = 1'b0;
                wait_left--;
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge Clock);
        #1;
        drive_memory();
    endtask

    // run one table entry until the next pc shows up on the bus
    task automatic run_entry(cpu_bus_pkg::addr_t cur_pc, output cpu_bus_pkg::addr_t next_pc);
        entry_t                e;
        cpu_bus_pkg::bus_req_t first;
        logic                  in_access;
        logic                  store_seen;
        logic                  done;
        e          = program_q[cur_pc >> 2];
        in_access  = 1'b0;
        store_seen = 1'b0;
        done       = 1'b0;
        while (!done) begin
            step_cycle();
            if (!bus.as_l) begin
                if (!in_access) begin
                    first     = bus;
                    in_access = 1'b1;
                    if (!bus.we_l) begin
                        store_seen = 1'b1;
                        if (e.has_store) begin
                            check_store("bus", e.store, bus);
                        end else begin
                            errors++;
                            $display("unexpected store from instruction at pc %h", cur_pc);
                        end
                    end
                end else begin
                    // request must hold until acknowledged
                    check_store("bus (held)", first, bus);
                end
            end else if (bus.addr != cur_pc) begin
                done = 1'b1;
            end
        end
        if (e.has_store && !store_seen) begin
            errors++;
            $display("no store request from instruction at pc %h", cur_pc);
        end
        check_fetch("bus.addr", e.next_pc, bus.addr);
        next_pc = bus.addr;
    endtask

    // counts every clock and stops a run that never reaches the end of the table
    initial begin
        do begin
            @(posedge Clock);
            cycles++;
        end while (cycles <= cycle_limit);
        errors++;
        $display("timeout waiting for bus activity after %0d cycles", cycles);
        finish_run();
    end

    initial begin
        Clock       = 1'b0;
        Reset_L     = 1'b0;
        instruction = 32'h0;
        data_in     = LOAD_DATA;
        dtack       = 1'b0;
        errors      = 0;
        cycles      = 0;
        wait_left   = 0;
        mem_busy    = 1'b0;
        acked       = 1'b0;
        build_program();
        cycle_limit = program_q.size() * CYCLES_PER_ENTRY + RESET_CYCLES;
        repeat (RESET_CYCLES) step_cycle();
        check_fetch("bus.addr", cpu_isa_pkg::RESET_PC, bus.addr);
        check_strobe("bus.as_l", 1'b1, bus.as_l);
        check_strobe("bus.we_l", 1'b1, bus.we_l);
        Reset_L = 1'b1;
        pc = cpu_isa_pkg::RESET_PC;
        while ((pc >> 2) < program_q.size()) begin
            run_entry(pc, pc);
        end
        finish_run();
    end

endmodule

// ==== verilog.f ====
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/reg_file.sv
hw/alu.sv
hw/load_store_unit.sv
hw/control_fsm.sv
hw/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run tb_cpu and check the log"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_cpu -Mdir obj_dir -f verilog.f
	./obj_dir/Vtb_cpu | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
